// File: video_pkg.sv
`default_nettype none

package video_pkg;

    // pixel or line coordinate.
    typedef logic [9:0] coord_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef logic [3:0] palette_idx_t;

    // glyph body spans these rows of the 16-line cell.
    localparam logic [3:0] glyph_first_row = 4'd2;
    localparam logic [3:0] glyph_last_row = 4'd13;

    // character code of the top band.
    localparam logic [7:0] char_base = 8'h30;

endpackage

`default_nettype wire

// File: packet_pkg.sv
`default_nettype none

package packet_pkg;

    // data-island packet header codes.
    typedef enum logic [7:0] {
        pkt_null            = 8'h00,
        pkt_acr             = 8'h01,
        pkt_audio_sample    = 8'h02,
        pkt_audio_infoframe = 8'h84
    } packet_type_t;

    // per-frame scheduler progress.
    typedef enum logic [1:0] {
        phase_acr,
        phase_info,
        phase_stream
    } sched_phase_t;

endpackage

`default_nettype wire

// File: video_timing.sv
`default_nettype none

module video_timing
    import video_pkg::*;
#(
    parameter int h_active = 640,
    parameter int h_total  = 800,
    parameter int v_active = 480,
    parameter int v_total  = 525
)
(
    input  logic   clk_pixel,
    input  logic   arst_n,
    output coord_t cx,
    output coord_t cy,
    output logic   de,
    output logic   island_strobe,
    output logic   frame_start
);

    logic line_end;
    logic frame_end;

    assign line_end  = (cx == coord_t'(h_total - 1));
    assign frame_end = (cy == coord_t'(v_total - 1));

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cx <= '0;
            cy <= '0;
        end
        else
        begin
            if (line_end)
            begin
                cx <= '0;
                if (frame_end)
                begin
                    cy <= '0;
                end
                else
                begin
                    cy <= cy + coord_t'(1);
                end
            end
            else
            begin
                cx <= cx + coord_t'(1);
            end
        end
    end

    assign de = (cx < coord_t'(h_active)) && (cy < coord_t'(v_active));

    // one island slot opens right after the active part of each line.
    assign island_strobe = (cx == coord_t'(h_active));

    assign frame_start = (cx == '0) && (cy == '0);

    a_cx_range: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        cx < coord_t'(h_total));

endmodule

`default_nettype wire

// File: sawtooth_tone.sv
`default_nettype none

module sawtooth_tone #(
    parameter int sample_width = 16,
    parameter int sample_div   = 525,
    parameter int wave_step    = 1365
)
(
    input  logic                    clk_pixel,
    input  logic                    arst_n,
    output logic                    sample_strobe,
    output logic [sample_width-1:0] level,
    output logic                    pwm_out
);

    localparam int div_w = $clog2(sample_div);

    logic [div_w-1:0]      div_cnt;
    logic                  div_wrap;
    logic [sample_width:0] pwm_acc;

    assign div_wrap = (div_cnt == div_w'(sample_div - 1));

    // strobe and new level appear on the same edge.
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt       <= '0;
            sample_strobe <= 1'b0;
            level         <= '0;
        end
        else
        begin
            sample_strobe <= div_wrap;
            if (div_wrap)
            begin
                div_cnt <= '0;
                level   <= level + sample_width'(wave_step);
            end
            else
            begin
                div_cnt <= div_cnt + div_w'(1);
            end
        end
    end

    // first-order delta-sigma, the carry out is the pulse density.
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pwm_acc <= '0;
        end
        else
        begin
            pwm_acc <= {1'b0, pwm_acc[sample_width-1:0]} + {1'b0, level};
        end
    end

    assign pwm_out = pwm_acc[sample_width];

endmodule

`default_nettype wire

// File: sample_fifo.sv
`default_nettype none

module sample_fifo #(
    parameter int sample_width = 16,
    parameter int fifo_depth   = 16
)
(
    input  logic                    clk_pixel,
    input  logic                    arst_n,
    input  logic                    sample_strobe,
    input  logic                    pop,
    input  logic [sample_width-1:0] level,
    output logic [sample_width-1:0] head,
    output logic [6:0]              remaining
);

    localparam int ptr_w = $clog2(fifo_depth);

    logic [sample_width-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]        wr_ptr;
    logic [ptr_w-1:0]        rd_ptr;
    logic                    full;
    logic                    push_ok;

    assign full    = (remaining == 7'(fifo_depth));
    // samples arriving while full are lost.
    assign push_ok = sample_strobe && !full;

    always_ff @(posedge clk_pixel)
    begin
        if (push_ok)
        begin
            mem[wr_ptr] <= level;
        end
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            remaining <= '0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr <= wr_ptr + ptr_w'(1);
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + ptr_w'(1);
            end
            case ({push_ok, pop})
                2'b10:   remaining <= remaining + 7'd1;
                2'b01:   remaining <= remaining - 7'd1;
                default: remaining <= remaining;
            endcase
        end
    end

    assign head = mem[rd_ptr];

    a_fill_bound: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        remaining <= 7'(fifo_depth));

    // the scheduler must never request from an empty buffer.
    a_no_underflow: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        !(pop && remaining == 7'd0));

endmodule

`default_nettype wire

// File: packet_scheduler.sv
`default_nettype none

module packet_scheduler
    import packet_pkg::*;
#(
    parameter int sample_width = 16
)
(
    input  logic                    clk_pixel,
    input  logic                    arst_n,
    input  logic                    island_strobe,
    input  logic                    frame_start,
    input  logic [6:0]              remaining,
    input  logic [sample_width-1:0] head,
    output logic                    pop,
    output packet_type_t            packet_type,
    output logic [sample_width-1:0] packet_sample,
    output logic                    packet_valid
);

    sched_phase_t phase;

    assign pop = island_strobe && (phase == phase_stream) && (remaining != 7'd0);

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase        <= phase_acr;
            packet_type  <= pkt_null;
            packet_valid <= 1'b0;
        end
        else
        begin
            packet_valid <= island_strobe;
            if (frame_start)
            begin
                phase <= phase_acr;
            end
            else if (island_strobe)
            begin
                case (phase)
                    phase_acr:
                    begin
                        packet_type <= pkt_acr;
                        phase       <= phase_info;
                    end
                    phase_info:
                    begin
                        packet_type <= pkt_audio_infoframe;
                        phase       <= phase_stream;
                    end
                    phase_stream:
                    begin
                        packet_type <= pop ? pkt_audio_sample : pkt_null;
                    end
                    default:
                    begin
                        packet_type <= pkt_null;
                        phase       <= phase_acr;
                    end
                endcase
            end
        end
    end

    // sample word only moves with an audio packet.
    always_ff @(posedge clk_pixel)
    begin
        if (pop)
        begin
            packet_sample <= head;
        end
    end

    // strobes are a line apart, so each valid is a lone pulse.
    a_valid_pulse: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        island_strobe |=> packet_valid ##1 !packet_valid);

endmodule

`default_nettype wire

// File: text_console.sv
`default_nettype none

module text_console
    import video_pkg::*;
(
    input  logic   clk_pixel,
    input  logic   arst_n,
    input  logic   de,
    input  coord_t cx,
    input  coord_t cy,
    output rgb_t   rgb
);

    logic [7:0]   char_code;
    logic [7:0]   char_next;
    logic [5:0]   prev_band;
    palette_idx_t bg_idx;
    palette_idx_t fg_idx;
    logic [2:0]   bit_sel;
    logic         glyph_row;
    logic         lit;

    function automatic rgb_t palette(input palette_idx_t idx);
        rgb_t       col;
        logic [7:0] lvl;
        lvl       = idx[3] ? 8'hFF : 8'h80;
        col.red   = idx[2] ? lvl : 8'h00;
        col.green = idx[1] ? lvl : 8'h00;
        col.blue  = idx[0] ? lvl : 8'h00;
        return col;
    endfunction

    // code for the current band, valid already on the band's first pixel.
    always_comb
    begin
        if (cy == '0)
        begin
            char_next = char_base;
        end
        else if (prev_band != cy[9:4])
        begin
            char_next = char_code + 8'd1;
        end
        else
        begin
            char_next = char_code;
        end
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            char_code <= char_base;
            prev_band <= '0;
        end
        else
        begin
            char_code <= char_next;
            prev_band <= cy[9:4];
        end
    end

    assign bg_idx = {cx[9], cy[8:6]};
    assign fg_idx = cx[8:5];

    // leftmost pixel of the cell shows the msb of the code.
    assign bit_sel   = 3'd7 - cx[2:0];
    assign glyph_row = (cy[3:0] >= glyph_first_row) && (cy[3:0] <= glyph_last_row);
    assign lit       = glyph_row && char_next[bit_sel];

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rgb <= '0;
        end
        else if (de)
        begin
            rgb <= lit ? palette(fg_idx) : palette(bg_idx);
        end
        else
        begin
            rgb <= '0;
        end
    end

endmodule

`default_nettype wire

// File: hdmi_source_top.sv
`default_nettype none

module hdmi_source_top
    import video_pkg::*;
    import packet_pkg::*;
#(
    parameter int h_active     = 640,
    parameter int h_total      = 800,
    parameter int v_active     = 480,
    parameter int v_total      = 525,
    parameter int sample_width = 16,
    parameter int sample_div   = 525,
    parameter int wave_step    = 1365,
    parameter int fifo_depth   = 16
)
(
    input  logic                    clk_pixel,
    input  logic                    arst_n,
    output rgb_t                    rgb,
    output logic                    de,
    output coord_t                  cx,
    output coord_t                  cy,
    output packet_type_t            packet_type,
    output logic [sample_width-1:0] packet_sample,
    output logic                    packet_valid,
    output logic                    pwm_out
);

    logic                    island_strobe;
    logic                    frame_start;
    logic                    sample_strobe;
    logic [sample_width-1:0] level;
    logic [sample_width-1:0] head;
    logic [6:0]              remaining;
    logic                    pop;

    video_timing #(
        .h_active(h_active),
        .h_total (h_total),
        .v_active(v_active),
        .v_total (v_total)
    ) video_timing_i (
        .clk_pixel    (clk_pixel),
        .arst_n       (arst_n),
        .cx           (cx),
        .cy           (cy),
        .de           (de),
        .island_strobe(island_strobe),
        .frame_start  (frame_start)
    );

    sawtooth_tone #(
        .sample_width(sample_width),
        .sample_div  (sample_div),
        .wave_step   (wave_step)
    ) sawtooth_tone_i (
        .clk_pixel    (clk_pixel),
        .arst_n       (arst_n),
        .sample_strobe(sample_strobe),
        .level        (level),
        .pwm_out      (pwm_out)
    );

    sample_fifo #(
        .sample_width(sample_width),
        .fifo_depth  (fifo_depth)
    ) sample_fifo_i (
        .clk_pixel    (clk_pixel),
        .arst_n       (arst_n),
        .sample_strobe(sample_strobe),
        .pop          (pop),
        .level        (level),
        .head         (head),
        .remaining    (remaining)
    );

    packet_scheduler #(
        .sample_width(sample_width)
    ) packet_scheduler_i (
        .clk_pixel    (clk_pixel),
        .arst_n       (arst_n),
        .island_strobe(island_strobe),
        .frame_start  (frame_start),
        .remaining    (remaining),
        .head         (head),
        .pop          (pop),
        .packet_type  (packet_type),
        .packet_sample(packet_sample),
        .packet_valid (packet_valid)
    );

    text_console text_console_i (
        .clk_pixel(clk_pixel),
        .arst_n   (arst_n),
        .de       (de),
        .cx       (cx),
        .cy       (cy),
        .rgb      (rgb)
    );

endmodule

`default_nettype wire

// File: tb_hdmi_source.sv
`default_nettype none

module tb_hdmi_source
    import video_pkg::*;
    import packet_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int h_active    = 64;
    localparam int h_total     = 80;
    localparam int v_active    = 48;
    localparam int v_total     = 52;
    localparam int sample_div  = 100;
    localparam int wave_step   = 1000;
    localparam int fifo_depth  = 16;
    localparam int frame_cycles = h_total * v_total;

    logic         clk_pixel;
    logic         arst_n;
    rgb_t         rgb;
    logic         de;
    coord_t       cx;
    coord_t       cy;
    packet_type_t packet_type;
    logic [15:0]  packet_sample;
    logic         packet_valid;
    logic         pwm_out;

    // reference model state, registered alongside the DUT.
    coord_t       m_cx;
    coord_t       m_cy;
    logic         m_de;
    logic         m_valid;
    rgb_t         m_rgb;
    logic [6:0]   m_div;
    logic [15:0]  m_level;
    logic         m_strobe;
    logic [15:0]  m_phase;
    logic         m_pwm;
    int           m_pushes;
    int           m_audio;
    int           m_fill;
    logic [1:0]   m_slot;
    packet_type_t m_exp_type;
    logic [15:0]  m_last_sample;
    logic         m_frame_end;

    // packets seen at the DUT outputs.
    int           seen_audio;
    int           seen_nulls;
    int           seen_frame_audio;

    hdmi_source_top #(
        .h_active    (h_active),
        .h_total     (h_total),
        .v_active    (v_active),
        .v_total     (v_total),
        .sample_width(16),
        .sample_div  (sample_div),
        .wave_step   (wave_step),
        .fifo_depth  (fifo_depth)
    ) hdmi_source_top_i (
        .clk_pixel    (clk_pixel),
        .arst_n       (arst_n),
        .rgb          (rgb),
        .de           (de),
        .cx           (cx),
        .cy           (cy),
        .packet_type  (packet_type),
        .packet_sample(packet_sample),
        .packet_valid (packet_valid),
        .pwm_out      (pwm_out)
    );

    always #50 clk_pixel = ~clk_pixel;

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("error at %0t ns: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t ns", what, $time);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // colour of one pixel from the character, attribute and palette rules.
    function automatic rgb_t expected_rgb(input coord_t x, input coord_t y);
        logic [7:0] code;
        logic       on;
        logic [3:0] idx;
        logic [7:0] lvl;
        rgb_t       col;
        code = char_base + {2'b00, y[9:4]};
        on   = (y[3:0] >= glyph_first_row) && (y[3:0] <= glyph_last_row)
               && (((code << x[2:0]) & 8'h80) != 8'h00);
        idx  = on ? x[8:5] : {x[9], y[8:6]};
        lvl  = idx[3] ? 8'hFF : 8'h80;
        col  = {idx[2] ? lvl : 8'h00, idx[1] ? lvl : 8'h00, idx[0] ? lvl : 8'h00};
        if ((x < coord_t'(h_active)) && (y < coord_t'(v_active)))
        begin
            return col;
        end
        else
        begin
            return '0;
        end
    endfunction

    always_comb m_fill = m_pushes - m_audio;
    always_comb m_de = (m_cx < coord_t'(h_active)) && (m_cy < coord_t'(v_active));
    always_comb m_frame_end = (m_cx == coord_t'(h_total - 1)) && (m_cy == coord_t'(v_total - 1));

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            m_cx    <= '0;
            m_cy    <= '0;
            m_valid <= 1'b0;
            m_rgb   <= '0;
        end
        else
        begin
            if (m_cx == coord_t'(h_total - 1))
            begin
                m_cx <= '0;
                m_cy <= (m_cy == coord_t'(v_total - 1)) ? '0 : m_cy + 10'd1;
            end
            else
            begin
                m_cx <= m_cx + 10'd1;
            end
            m_valid <= (m_cx == coord_t'(h_active));
            m_rgb   <= expected_rgb(m_cx, m_cy);
        end
    end

    // sawtooth source, delta-sigma and push count.
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            m_div    <= '0;
            m_level  <= '0;
            m_strobe <= 1'b0;
            m_phase  <= '0;
            m_pwm    <= 1'b0;
            m_pushes <= 0;
        end
        else
        begin
            m_strobe <= (m_div == 7'(sample_div - 1));
            if (m_div == 7'(sample_div - 1))
            begin
                m_div   <= '0;
                m_level <= m_level + 16'(wave_step);
            end
            else
            begin
                m_div <= m_div + 7'd1;
            end
            // a pulse whenever the phase sum overflows 16 bits.
            m_phase <= m_phase + m_level;
            m_pwm   <= (int'(m_phase) + int'(m_level)) >= 65536;
            if (m_strobe)
            begin
                m_pushes <= m_pushes + 1;
            end
        end
    end

    // expected packet for each island slot.
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            m_slot        <= 2'd0;
            m_exp_type    <= pkt_null;
            m_audio       <= 0;
            m_last_sample <= '0;
        end
        else if ((m_cx == '0) && (m_cy == '0))
        begin
            m_slot <= 2'd0;
        end
        else if (m_cx == coord_t'(h_active))
        begin
            if (m_slot != 2'd2)
            begin
                m_slot <= m_slot + 2'd1;
            end
            if (m_slot == 2'd0)
            begin
                m_exp_type <= pkt_acr;
            end
            else if (m_slot == 2'd1)
            begin
                m_exp_type <= pkt_audio_infoframe;
            end
            else if (m_fill != 0)
            begin
                m_exp_type    <= pkt_audio_sample;
                m_audio       <= m_audio + 1;
                m_last_sample <= m_last_sample + 16'(wave_step);
            end
            else
            begin
                m_exp_type <= pkt_null;
            end
        end
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            seen_audio       <= 0;
            seen_nulls       <= 0;
            seen_frame_audio <= 0;
        end
        else
        begin
            if (packet_valid && (packet_type == pkt_audio_sample))
            begin
                seen_audio <= seen_audio + 1;
            end
            if (m_frame_end)
            begin
                seen_nulls       <= 0;
                seen_frame_audio <= 0;
            end
            else if (packet_valid && (packet_type == pkt_null))
            begin
                seen_nulls <= seen_nulls + 1;
            end
            else if (packet_valid && (packet_type == pkt_audio_sample))
            begin
                seen_frame_audio <= seen_frame_audio + 1;
            end
        end
    end

    a_cx: assert property (@(posedge clk_pixel) disable iff (!arst_n) cx == m_cx)
        else report_mismatch("cx", 64'($sampled(m_cx)), 64'($sampled(cx)));

    a_cy: assert property (@(posedge clk_pixel) disable iff (!arst_n) cy == m_cy)
        else report_mismatch("cy", 64'($sampled(m_cy)), 64'($sampled(cy)));

    a_de: assert property (@(posedge clk_pixel) disable iff (!arst_n) de == m_de)
        else report_mismatch("de", 64'($sampled(m_de)), 64'($sampled(de)));

    a_valid: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        packet_valid == m_valid)
        else report_mismatch("packet_valid", 64'($sampled(m_valid)),
                             64'($sampled(packet_valid)));

    a_type: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        packet_valid |-> packet_type == m_exp_type)
        else report_mismatch("packet_type", 64'($sampled(m_exp_type)),
                             64'($sampled(packet_type)));

    a_sample: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        (packet_valid && m_exp_type == pkt_audio_sample) |-> packet_sample == m_last_sample)
        else report_mismatch("packet_sample", 64'($sampled(m_last_sample)),
                             64'($sampled(packet_sample)));

    a_rgb: assert property (@(posedge clk_pixel) disable iff (!arst_n) rgb == m_rgb)
        else report_mismatch("rgb", 64'($sampled(m_rgb)), 64'($sampled(rgb)));

    a_pwm: assert property (@(posedge clk_pixel) disable iff (!arst_n) pwm_out == m_pwm)
        else report_mismatch("pwm_out", 64'($sampled(m_pwm)), 64'($sampled(pwm_out)));

    a_backlog: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        (seen_audio <= m_pushes) && (m_fill <= fifo_depth))
        else report_failure("audio packets outran the samples or the FIFO overflowed");

    a_frame_mix: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        m_frame_end |-> (seen_nulls > 0) && (seen_frame_audio > 0))
        else report_failure("a frame ended without both null and audio sample packets");

    task automatic wait_frame_start(input int frame);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && (cycles < 2 * frame_cycles))
        begin
            @(negedge clk_pixel);
            cycles++;
            seen = (cx == '0) && (cy == '0);
        end
        if (!seen)
        begin
            report_failure($sformatf("timeout waiting for the start of frame %0d", frame));
        end
    endtask

    initial
    begin
        clk_pixel = 1'b0;
        arst_n    = 1'b0;
        repeat (8) @(negedge clk_pixel);
        arst_n = 1'b1;
        // three full frames, the last one ends as the fourth starts.
        for (int f = 1; f <= 3; f++)
        begin
            wait_frame_start(f + 1);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
video_pkg.sv
packet_pkg.sv
video_timing.sv
sawtooth_tone.sv
sample_fifo.sv
packet_scheduler.sv
text_console.sv
hdmi_source_top.sv
tb_hdmi_source.sv

// File: Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_hdmi_source
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# the run passes only if the log holds the pass line.
sim:
	rm -f $(LOG)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
